/* rtl/u2_ctrl_pkg.sv */
// Shared definitions for the slow-control block
// Bus widths, settings addresses, address map and bus structs

package u2_ctrl_pkg;

   ////////////////////////////////////////
   // Bus widths
   localparam int DW  = 32;
   localparam int AW  = 16;
   localparam int SW  = 4;
   localparam int SAW = 8;

   ////////////////////////////////////////
   // Settings register map
   localparam logic [SAW-1:0] SR_MISC        = 8'd0;
   localparam logic [SAW-1:0] MISC_CLK_OFS   = 8'd0;
   localparam logic [SAW-1:0] MISC_SER_OFS   = 8'd1;
   localparam logic [SAW-1:0] MISC_ADC_OFS   = 8'd2;
   localparam logic [SAW-1:0] MISC_LED_OFS   = 8'd3;
   localparam logic [SAW-1:0] MISC_PHY_OFS   = 8'd4;
   localparam logic [SAW-1:0] MISC_LSRC_OFS  = 8'd6;

   localparam logic [SAW-1:0] SR_TIME64      = 8'd10;
   localparam logic [SAW-1:0] TIME_HI_OFS    = 8'd0;
   localparam logic [SAW-1:0] TIME_LO_OFS    = 8'd1;
   localparam logic [SAW-1:0] TIME_CTRL_OFS  = 8'd2;
   // Bits of the load control word
   localparam int LOAD_NOW_BIT = 0;
   localparam int LOAD_PPS_BIT = 1;

   ////////////////////////////////////////
   // Wishbone address map
   localparam logic [AW-1:0] SETTINGS_BASE = 16'h7000;
   localparam logic [AW-1:0] READBACK_BASE = 16'h5C00;

   // Readback word indices
   localparam logic [3:0] RB_STATUS  = 4'd8;
   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_IRQ     = 4'd13;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

   ////////////////////////////////////////
   // Bus structs
   typedef struct packed {
      logic          cyc;
      logic          stb;
      logic          we;
      logic [AW-1:0] adr;
      logic [SW-1:0] sel;
      logic [DW-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic          ack;
      logic [DW-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic           stb;
      logic [SAW-1:0] addr;
      logic [DW-1:0]  data;
   } set_bus_t;

   // Board control lines, in settings bit order
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
   } misc_ctl_t;

endpackage

/* rtl/wb_decoder.sv */
// Wishbone address decoder
// Routes cycles to the settings writer or the readback slave,
// and acks unmapped cycles with zero data

`timescale 1ns/1ps

module wb_decoder (
   input  logic                 dsp_clk,
   input  logic                 rst_i,
   input  u2_ctrl_pkg::wb_req_t wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t wb_rsp_o,
   output u2_ctrl_pkg::wb_req_t set_req_o,
   input  u2_ctrl_pkg::wb_rsp_t set_rsp_i,
   output u2_ctrl_pkg::wb_req_t rb_req_o,
   input  u2_ctrl_pkg::wb_rsp_t rb_rsp_i
);

   logic set_hit;
   logic rb_hit;
   logic nomap_ack_q;

   // Settings space is 1K, readback is 64 bytes
   assign set_hit = (wb_req_i.adr[15:10] == u2_ctrl_pkg::SETTINGS_BASE[15:10]);
   assign rb_hit  = (wb_req_i.adr[15:6] == u2_ctrl_pkg::READBACK_BASE[15:6]);

   always_comb begin
      set_req_o     = wb_req_i;
      set_req_o.stb = wb_req_i.stb & set_hit;
      rb_req_o      = wb_req_i;
      rb_req_o.stb  = wb_req_i.stb & rb_hit;
   end

   // Local ack so an unmapped cycle still terminates
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         nomap_ack_q <= 1'b0;
      end else begin
         nomap_ack_q <= wb_req_i.cyc & wb_req_i.stb & ~set_hit & ~rb_hit & ~nomap_ack_q;
      end
   end

   always_comb begin
      if (set_hit) begin
         wb_rsp_o = set_rsp_i;
      end else if (rb_hit) begin
         wb_rsp_o = rb_rsp_i;
      end else begin
         wb_rsp_o = '{ack: nomap_ack_q, dat: '0};
      end
   end

   // Only one responder may ack in any cycle
   a_one_ack : assert property (@(posedge dsp_clk) disable iff (rst_i)
      $onehot0({set_rsp_i.ack, rb_rsp_i.ack, nomap_ack_q}))
      else $error("more than one slave acked");

endmodule

/* rtl/settings_bus.sv */
// Settings writer
// Turns Wishbone writes into single-cycle settings strobes

`timescale 1ns/1ps

module settings_bus (
   input  logic                  dsp_clk,
   input  logic                  rst_i,
   input  u2_ctrl_pkg::wb_req_t  wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t  wb_rsp_o,
   output u2_ctrl_pkg::set_bus_t set_o
);

   logic                        ack_q;
   logic                        stb_q;
   logic [u2_ctrl_pkg::SAW-1:0] addr_q;
   logic [u2_ctrl_pkg::DW-1:0]  data_q;

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
         stb_q <= wb_req_i.cyc & wb_req_i.stb & wb_req_i.we & ~ack_q;
      end
   end

   // Word address within the 1K settings window
   always_ff @(posedge dsp_clk) begin
      addr_q <= wb_req_i.adr[9:2];
      data_q <= wb_req_i.dat;
   end

   assign set_o        = '{stb: stb_q, addr: addr_q, data: data_q};
   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = '0;

   a_ack_single : assert property (@(posedge dsp_clk) disable iff (rst_i)
      (ack_q || stb_q) |=> !(ack_q || stb_q))
      else $error("settings ack or strobe held two cycles");

endmodule

/* rtl/misc_ctrl.sv */
// Miscellaneous control registers
// Clock, SERDES, ADC and PHY control lines plus the LED source mix

`timescale 1ns/1ps

module misc_ctrl #(
   parameter logic [7:0] LED_SRC_RESET = 8'h1E
) (
   input  logic                   dsp_clk,
   input  logic                   rst_i,
   input  u2_ctrl_pkg::set_bus_t  set_i,
   input  logic                   run_rx_i,
   input  logic                   run_tx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   input  logic                   good_sync_i,
   output u2_ctrl_pkg::misc_ctl_t misc_ctl_o,
   output logic                   phy_resetn_o,
   output logic [7:0]             leds_o
);

   localparam logic [7:0] ADDR_CLK  = u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_CLK_OFS;
   localparam logic [7:0] ADDR_SER  = u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_SER_OFS;
   localparam logic [7:0] ADDR_ADC  = u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_ADC_OFS;
   localparam logic [7:0] ADDR_LED  = u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_LED_OFS;
   localparam logic [7:0] ADDR_PHY  = u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_PHY_OFS;
   localparam logic [7:0] ADDR_LSRC = u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_LSRC_OFS;

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic       phy_reset;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   ////////////////////////////////////////
   // Setting registers
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         clk_reg   <= '0;
         ser_reg   <= '0;
         adc_reg   <= '0;
         led_sw    <= '0;
         phy_reset <= 1'b0;
         led_src   <= LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            ADDR_CLK:  clk_reg   <= set_i.data[4:0];
            ADDR_SER:  ser_reg   <= set_i.data[3:0];
            ADDR_ADC:  adc_reg   <= set_i.data[3:0];
            ADDR_LED:  led_sw    <= set_i.data[7:0];
            ADDR_PHY:  phy_reset <= set_i.data[0];
            ADDR_LSRC: led_src   <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   // Field order of the struct matches the register bit order
   assign misc_ctl_o   = {clk_reg, ser_reg, adc_reg};
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////
   // LED mix
   // Source bit 1 picks the hardware state, 0 the software bit
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i & good_sync_i, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* rtl/time_64bit.sv */
// 64-bit VITA time counter
// Loads immediately or on the next PPS edge, latches time at each PPS edge

`timescale 1ns/1ps

module time_64bit (
   input  logic                  dsp_clk,
   input  logic                  rst_i,
   input  u2_ctrl_pkg::set_bus_t set_i,
   input  logic                  pps_i,
   output logic [63:0]           vita_time_o,
   output logic [63:0]           vita_time_pps_o,
   output logic                  good_sync_o
);

   localparam logic [7:0] ADDR_HI   = u2_ctrl_pkg::SR_TIME64 + u2_ctrl_pkg::TIME_HI_OFS;
   localparam logic [7:0] ADDR_LO   = u2_ctrl_pkg::SR_TIME64 + u2_ctrl_pkg::TIME_LO_OFS;
   localparam logic [7:0] ADDR_CTRL = u2_ctrl_pkg::SR_TIME64 + u2_ctrl_pkg::TIME_CTRL_OFS;

   logic [31:0] time_hi_q;
   logic [31:0] time_lo_q;
   logic        ctrl_wr;
   logic        load_now;
   logic        load_pps;
   logic        pps_pending;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_del;
   logic        pps_edge;

   // Staged time words
   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && set_i.addr == ADDR_HI) begin
         time_hi_q <= set_i.data;
      end
      if (set_i.stb && set_i.addr == ADDR_LO) begin
         time_lo_q <= set_i.data;
      end
   end

   assign ctrl_wr  = set_i.stb && (set_i.addr == ADDR_CTRL);
   assign load_now = ctrl_wr && set_i.data[u2_ctrl_pkg::LOAD_NOW_BIT];
   assign load_pps = ctrl_wr && set_i.data[u2_ctrl_pkg::LOAD_PPS_BIT];

   ////////////////////////////////////////
   // PPS sync and edge detect
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_del  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_del  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_del;

   ////////////////////////////////////////
   // Counter, armed load and PPS latch
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_pending     <= 1'b0;
         good_sync_o     <= 1'b0;
      end else begin
         vita_time_o <= vita_time_o + 64'd1;
         if (load_now) begin
            vita_time_o <= {time_hi_q, time_lo_q};
         end
         if (load_pps) begin
            pps_pending <= 1'b1;
         end
         if (pps_edge) begin
            // Latch the running value before any load
            vita_time_pps_o <= vita_time_o;
            if (pps_pending) begin
               vita_time_o <= {time_hi_q, time_lo_q};
               pps_pending <= 1'b0;
               good_sync_o <= 1'b1;
            end
         end
      end
   end

   a_load_now : assert property (@(posedge dsp_clk) disable iff (rst_i)
      (load_now && !(pps_edge && pps_pending)) |=>
         (vita_time_o == {$past(time_hi_q), $past(time_lo_q)}))
      else $error("immediate time load missed");

endmodule

/* rtl/readback_mux.sv */
// Readback slave
// Returns one of sixteen status words over Wishbone

`timescale 1ns/1ps

module readback_mux #(
   parameter logic [31:0] COMPAT_NUM = {16'd9, 16'd0}
) (
   input  logic                 dsp_clk,
   input  logic                 rst_i,
   input  u2_ctrl_pkg::wb_req_t wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t wb_rsp_o,
   input  logic [31:0]          status_i,
   input  logic [63:0]          vita_time_i,
   input  logic [63:0]          vita_time_pps_i,
   input  logic                 clk_status_i,
   input  logic                 serdes_link_up_i
);

   logic        ack_q;
   logic [31:0] dat_q;
   logic [31:0] irq_word;
   logic [31:0] rd_word;

   assign irq_word = {20'd0, clk_status_i, serdes_link_up_i, 10'd0};

   always_comb begin
      case (wb_req_i.adr[5:2])
         u2_ctrl_pkg::RB_STATUS:  rd_word = status_i;
         u2_ctrl_pkg::RB_TIME_HI: rd_word = vita_time_i[63:32];
         u2_ctrl_pkg::RB_TIME_LO: rd_word = vita_time_i[31:0];
         u2_ctrl_pkg::RB_COMPAT:  rd_word = COMPAT_NUM;
         u2_ctrl_pkg::RB_IRQ:     rd_word = irq_word;
         u2_ctrl_pkg::RB_PPS_HI:  rd_word = vita_time_pps_i[63:32];
         u2_ctrl_pkg::RB_PPS_LO:  rd_word = vita_time_pps_i[31:0];
         default:                 rd_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
      end
   end

   // Sampled with the ack so data matches the request cycle
   always_ff @(posedge dsp_clk) begin
      dat_q <= rd_word;
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = dat_q;

   a_ack_after_stb : assert property (@(posedge dsp_clk) disable iff (rst_i)
      ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb))
      else $error("readback ack without request");

endmodule

/* rtl/u2_ctrl_top.sv */
// Slow-control top level
// Wishbone decoder, settings writer, readback slave, misc registers
// and the VITA time counter

`timescale 1ns/1ps

module u2_ctrl_top #(
   parameter logic [7:0]  LED_SRC_RESET = 8'h1E,
   parameter logic [31:0] COMPAT_NUM    = {16'd9, 16'd0}
) (
   input  logic                   dsp_clk,
   input  logic                   rst_i,
   input  u2_ctrl_pkg::wb_req_t   wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t   wb_rsp_o,
   input  logic                   pps_i,
   input  logic [31:0]            status_i,
   input  logic                   run_rx_i,
   input  logic                   run_tx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   output u2_ctrl_pkg::misc_ctl_t misc_ctl_o,
   output logic                   phy_resetn_o,
   output logic [7:0]             leds_o
);

   u2_ctrl_pkg::wb_req_t  set_req;
   u2_ctrl_pkg::wb_rsp_t  set_rsp;
   u2_ctrl_pkg::wb_req_t  rb_req;
   u2_ctrl_pkg::wb_rsp_t  rb_rsp;
   u2_ctrl_pkg::set_bus_t set_bus;
   logic [63:0]           vita_time;
   logic [63:0]           vita_time_pps;
   logic                  good_sync;

   ////////////////////////////////////////
   // Wishbone side
   wb_decoder i_wb_decoder (
      .dsp_clk   (dsp_clk),
      .rst_i     (rst_i),
      .wb_req_i  (wb_req_i),
      .wb_rsp_o  (wb_rsp_o),
      .set_req_o (set_req),
      .set_rsp_i (set_rsp),
      .rb_req_o  (rb_req),
      .rb_rsp_i  (rb_rsp)
   );

   settings_bus i_settings_bus (
      .dsp_clk  (dsp_clk),
      .rst_i    (rst_i),
      .wb_req_i (set_req),
      .wb_rsp_o (set_rsp),
      .set_o    (set_bus)
   );

   readback_mux #(.COMPAT_NUM(COMPAT_NUM)) i_readback_mux (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .wb_req_i         (rb_req),
      .wb_rsp_o         (rb_rsp),
      .status_i         (status_i),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i)
   );

   ////////////////////////////////////////
   // Settings bus units
   misc_ctrl #(.LED_SRC_RESET(LED_SRC_RESET)) i_misc_ctrl (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .set_i            (set_bus),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .misc_ctl_o       (misc_ctl_o),
      .phy_resetn_o     (phy_resetn_o),
      .leds_o           (leds_o)
   );

   time_64bit i_time_64bit (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .set_i           (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync)
   );

endmodule

/* bench/tb_u2_ctrl_tasks.svh */
// Bus tasks, checks and random source for the slow-control testbench
// Included inside the testbench module

`ifndef TB_U2_CTRL_TASKS_SVH
`define TB_U2_CTRL_TASKS_SVH

task automatic report_failure();
   $display("Result: FAILED");
   $fatal(1, "run stopped on first error");
endtask

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Byte address of a setting register
function automatic logic [15:0] settings_addr(input logic [7:0] sr);
   return u2_ctrl_pkg::SETTINGS_BASE | {6'd0, sr, 2'b00};
endfunction

////////////////////////////////////////
// Compare tasks
task automatic check_word(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act);
   if (act !== exp_val) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp_val, act);
      report_failure();
   end
endtask

task automatic check_word_min(input string name, input logic [31:0] min_val,
                              input logic [31:0] act);
   if ($isunknown(act) || act < min_val) begin
      $display("ERR t=%0t %s expected >= %h actual %h", $time, name, min_val, act);
      report_failure();
   end
endtask

task automatic check_misc(input u2_ctrl_pkg::misc_ctl_t exp_val,
                          input u2_ctrl_pkg::misc_ctl_t act);
   if (act !== exp_val) begin
      $display("ERR t=%0t misc_ctl_o expected %h actual %h", $time, exp_val, act);
      report_failure();
   end
endtask

task automatic check_leds(input logic [7:0] exp_val, input logic [7:0] act);
   if (act !== exp_val) begin
      $display("ERR t=%0t leds_o expected %h actual %h", $time, exp_val, act);
      report_failure();
   end
endtask

task automatic check_bit(input string name, input logic exp_val, input logic act);
   if (act !== exp_val) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp_val, act);
      report_failure();
   end
endtask

////////////////////////////////////////
// Wishbone classic master
task automatic wait_ack(input logic [15:0] addr, output logic [31:0] data);
   int cycles;
   cycles = 0;
   do begin
      @(posedge dsp_clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
         $display("No ack within %0d cycles for address %h", ACK_TIMEOUT, addr);
         report_failure();
      end
   end while (wb_rsp.ack !== 1'b1);
   data = wb_rsp.dat;
endtask

task automatic wb_write(input logic [15:0] addr, input logic [31:0] data);
   logic [31:0] rnd;
   logic [31:0] unused_dat;
   rnd = lcg_next();
   repeat (rnd[31:30]) @(posedge dsp_clk);
   @(posedge dsp_clk);
   wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, sel: 4'hF, dat: data};
   wait_ack(addr, unused_dat);
   wb_req <= '0;
   if (addr == settings_addr(u2_ctrl_pkg::SR_TIME64 + u2_ctrl_pkg::TIME_CTRL_OFS) &&
       data[u2_ctrl_pkg::LOAD_PPS_BIT]) begin
      pps_armed = 1'b1;
   end
endtask

task automatic wb_read(input logic [15:0] addr, output logic [31:0] data);
   logic [31:0] rnd;
   rnd = lcg_next();
   repeat (rnd[31:30]) @(posedge dsp_clk);
   @(posedge dsp_clk);
   wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, sel: 4'hF, dat: '0};
   wait_ack(addr, data);
   wb_req <= '0;
endtask

////////////////////////////////////////
// Stimulus helpers
// Long enough for the two-flop sync and the edge detect
task automatic pulse_pps();
   @(posedge dsp_clk);
   pps <= 1'b1;
   repeat (4) @(posedge dsp_clk);
   pps <= 1'b0;
   repeat (4) @(posedge dsp_clk);
   if (pps_armed) begin
      exp_good_sync = 1'b1;
      pps_armed     = 1'b0;
   end
endtask

task automatic led_mix_rounds(input logic [31:0] rounds);
   logic [31:0] rnd;
   logic [7:0]  sw_pat;
   logic [7:0]  src_pat;
   logic [7:0]  hw_word;
   logic [7:0]  exp_leds;
   for (int r = 0; r < int'(rounds); r++) begin
      rnd     = lcg_next();
      sw_pat  = rnd[31:24];
      rnd     = lcg_next();
      src_pat = rnd[31:24];
      rnd     = lcg_next();
      wb_write(settings_addr(u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_LED_OFS), {24'd0, sw_pat});
      wb_write(settings_addr(u2_ctrl_pkg::SR_MISC + u2_ctrl_pkg::MISC_LSRC_OFS),
               {24'd0, src_pat});
      @(posedge dsp_clk);
      {link_up, clk_status, run_tx, run_rx} <= rnd[31:28];
      @(posedge dsp_clk);
      // tx 4, rx 3, clock status 2, link with sync 1
      hw_word = {3'b000, rnd[29], rnd[28], rnd[30], rnd[31] & exp_good_sync, 1'b0};
      for (int b = 0; b < 8; b++) begin
         exp_leds[b] = src_pat[b] ? hw_word[b] : sw_pat[b];
      end
      check_leds(exp_leds, leds);
   end
endtask

`endif

/* bench/tb_u2_ctrl.sv */
// Testbench for the slow-control block
// Runs the operations of the vector file against the DUT

`timescale 1ns/1ps

module tb_u2_ctrl;

   localparam int          MAX_VEC       = 64;
   localparam int          ACK_TIMEOUT   = 16;
   localparam logic [7:0]  LED_SRC_RESET = 8'h1E;
   localparam logic [31:0] COMPAT_NUM    = {16'd9, 16'd0};

   // Vector opcodes
   localparam logic [31:0] OP_WRITE    = 32'h1;
   localparam logic [31:0] OP_READ     = 32'h2;
   localparam logic [31:0] OP_READ_MIN = 32'h3;
   localparam logic [31:0] OP_PPS      = 32'h4;
   localparam logic [31:0] OP_INPUTS   = 32'h5;
   localparam logic [31:0] OP_MISC     = 32'h6;
   localparam logic [31:0] OP_LEDS     = 32'h7;
   localparam logic [31:0] OP_END      = 32'hF;

   logic                   dsp_clk;
   logic                   rst_i;
   u2_ctrl_pkg::wb_req_t   wb_req;
   u2_ctrl_pkg::wb_rsp_t   wb_rsp;
   logic                   pps;
   logic [31:0]            status;
   logic                   run_rx;
   logic                   run_tx;
   logic                   clk_status;
   logic                   link_up;
   u2_ctrl_pkg::misc_ctl_t misc_ctl;
   logic                   phy_resetn;
   logic [7:0]             leds;

   logic [31:0]            vec_mem [0:4*MAX_VEC-1];
   int                     vec_count;
   logic                   vec_loaded;
   logic [31:0]            lcg_state;
   // Model state for the PPS-timed load
   logic                   pps_armed;
   logic                   exp_good_sync;

   `include "tb_u2_ctrl_tasks.svh"

   u2_ctrl_top #(
      .LED_SRC_RESET (LED_SRC_RESET),
      .COMPAT_NUM    (COMPAT_NUM)
   ) i_dut (
      .dsp_clk          (dsp_clk),
      .rst_i            (rst_i),
      .wb_req_i         (wb_req),
      .wb_rsp_o         (wb_rsp),
      .pps_i            (pps),
      .status_i         (status),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (link_up),
      .misc_ctl_o       (misc_ctl),
      .phy_resetn_o     (phy_resetn),
      .leds_o           (leds)
   );

   initial dsp_clk = 1'b0;
   always #4 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////
   // Watchdog, 64 cycles per vector
   initial begin
      wait (vec_loaded);
      #(vec_count * 64 * 8 + 1000);
      $display("Timeout: the vector run did not finish in time");
      report_failure();
   end

   ////////////////////////////////////////
   // Vector loop
   initial begin
      int          idx;
      logic [31:0] op;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [31:0] exp_val;
      logic [31:0] rd;
      rst_i         = 1'b1;
      wb_req        = '0;
      pps           = 1'b0;
      status        = '0;
      run_rx        = 1'b0;
      run_tx        = 1'b0;
      clk_status    = 1'b0;
      link_up       = 1'b0;
      lcg_state     = 32'h9636;
      pps_armed     = 1'b0;
      exp_good_sync = 1'b0;
      vec_loaded    = 1'b0;
      vec_count     = 0;
      $readmemh("bench/u2_ctrl_vectors.txt", vec_mem);
      while (vec_count < MAX_VEC && vec_mem[4*vec_count] !== OP_END) begin
         vec_count++;
      end
      if (vec_count == MAX_VEC) begin
         $display("Vector file has no end marker");
         report_failure();
      end
      vec_loaded = 1'b1;
      repeat (2) @(posedge dsp_clk);
      rst_i <= 1'b0;
      @(posedge dsp_clk);
      for (idx = 0; idx < vec_count; idx++) begin
         op      = vec_mem[4*idx];
         adr     = vec_mem[4*idx+1];
         dat     = vec_mem[4*idx+2];
         exp_val = vec_mem[4*idx+3];
         case (op)
            OP_WRITE: wb_write(adr[15:0], dat);
            OP_READ: begin
               wb_read(adr[15:0], rd);
               check_word($sformatf("wb_rsp_o.dat @%h", adr[15:0]), exp_val, rd);
            end
            OP_READ_MIN: begin
               wb_read(adr[15:0], rd);
               check_word_min($sformatf("wb_rsp_o.dat @%h", adr[15:0]), exp_val, rd);
            end
            OP_PPS: pulse_pps();
            OP_INPUTS: begin
               @(posedge dsp_clk);
               status <= dat;
               {link_up, clk_status, run_tx, run_rx} <= exp_val[3:0];
            end
            OP_MISC: begin
               @(posedge dsp_clk);
               check_misc(dat[12:0], misc_ctl);
               check_bit("phy_resetn_o", exp_val[8], phy_resetn);
               check_leds(exp_val[7:0], leds);
            end
            OP_LEDS: led_mix_rounds(dat);
            default: begin
               $display("Unknown opcode %h in vector %0d", op, idx);
               report_failure();
            end
         endcase
      end
      repeat (2) @(posedge dsp_clk);
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* bench/u2_ctrl_vectors.txt */
// op addr data expect; ops 1 write, 2 read, 3 read at least, 4 PPS pulse, 7 LED rounds, F end
// op 5 data=status expect={link,clk,tx,rx}; op 6 data=misc_ctl expect={phy_resetn,leds}
5 0000 A5C30F12 0000000D
2 5C30 00000000 00090000
2 5C20 00000000 A5C30F12
2 5C34 00000000 00000C00
6 0000 00000000 0000010C
1 7000 FFFFFFF5 00000000
6 0000 00001500 0000010C
1 7004 FFFFFFFA 00000000
6 0000 000015A0 0000010C
1 7008 0000000C 00000000
6 0000 000015AC 0000010C
1 7010 00000001 00000000
6 0000 000015AC 0000000C
7 0000 00000010 00000000
1 7028 12345678 00000000
1 702C 00001000 00000000
1 7030 00000001 00000000
2 5C28 00000000 12345678
3 5C2C 00000000 00001000
1 700C 00000000 00000000
1 7018 00000002 00000000
5 0000 A5C30F12 00000008
6 0000 000015AC 00000000
1 7028 9ABCDEF0 00000000
1 7030 00000002 00000000
2 5C28 00000000 12345678
4 0000 00000000 00000000
2 5C28 00000000 9ABCDEF0
2 5C38 00000000 12345678
6 0000 000015AC 00000002
2 1000 00000000 00000000
F 0000 00000000 00000000

/* project.f */
+incdir+bench
rtl/u2_ctrl_pkg.sv
rtl/wb_decoder.sv
rtl/settings_bus.sv
rtl/misc_ctrl.sv
rtl/time_64bit.sv
rtl/readback_mux.sv
rtl/u2_ctrl_top.sv
bench/tb_u2_ctrl.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat project.f)) bench/tb_u2_ctrl_tasks.svh

.PHONY: all run clean

all: obj_dir/Vtb_u2_ctrl

obj_dir/Vtb_u2_ctrl: $(SRCS) project.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module tb_u2_ctrl

run: obj_dir/Vtb_u2_ctrl
	@out="$$(./obj_dir/Vtb_u2_ctrl 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir
